/* src/decode_pkg.sv */
`default_nettype none

package decode_pkg;

  typedef logic [31:0] word_t;
  typedef logic [5:0]  opcode_t;
  typedef logic [3:0]  greg_id_t;
  typedef logic [1:0]  preg_id_t;
  typedef logic [3:0]  alu_op_t;

  typedef enum logic [1:0] {
    IMM_NONE = 2'b00,
    IMM_15   = 2'b01, // sign bit 14
    IMM_23   = 2'b10, // sign bit 22
    IMM_19   = 2'b11  // sign bit 18
  } imm_sel_t;

  typedef enum logic [1:0] {
    MASK_NONE = 2'b00,
    MASK_EI   = 2'b01,
    MASK_DI   = 2'b10,
    MASK_HALT = 2'b11
  } mask_t;

  localparam opcode_t OP_DI     = 6'h01;
  localparam opcode_t OP_EI     = 6'h02;
  localparam opcode_t OP_NEG    = 6'h05;
  localparam opcode_t OP_NOT    = 6'h06;
  localparam opcode_t OP_AND_R  = 6'h07;
  localparam opcode_t OP_OR_R   = 6'h08;
  localparam opcode_t OP_XOR_R  = 6'h09;
  localparam opcode_t OP_ADD_R  = 6'h0a;
  localparam opcode_t OP_SUB_R  = 6'h0b;
  localparam opcode_t OP_MUL_R  = 6'h0c;
  localparam opcode_t OP_DIV_R  = 6'h0d;
  localparam opcode_t OP_MOD_R  = 6'h0e;
  localparam opcode_t OP_SHL_R  = 6'h0f;
  localparam opcode_t OP_SHR_R  = 6'h10;
  localparam opcode_t OP_ANDI   = 6'h11;
  localparam opcode_t OP_ORI    = 6'h12;
  localparam opcode_t OP_XORI   = 6'h13;
  localparam opcode_t OP_ADDI   = 6'h14;
  localparam opcode_t OP_SUBI   = 6'h15;
  localparam opcode_t OP_MULI   = 6'h16;
  localparam opcode_t OP_DIVI   = 6'h17;
  localparam opcode_t OP_MODI   = 6'h18;
  localparam opcode_t OP_SHLI   = 6'h19;
  localparam opcode_t OP_SHRI   = 6'h1a;
  localparam opcode_t OP_JALI   = 6'h1b;
  localparam opcode_t OP_JALR   = 6'h1c;
  localparam opcode_t OP_JMPI   = 6'h1d;
  localparam opcode_t OP_JMPR   = 6'h1e;
  localparam opcode_t OP_LD     = 6'h23;
  localparam opcode_t OP_ST     = 6'h24;
  localparam opcode_t OP_LDI    = 6'h25;
  localparam opcode_t OP_RTOP   = 6'h26;
  localparam opcode_t OP_ANDP   = 6'h27;
  localparam opcode_t OP_ORP    = 6'h28;
  localparam opcode_t OP_XORP   = 6'h29;
  localparam opcode_t OP_NOTP   = 6'h2a;
  localparam opcode_t OP_ISNEG  = 6'h2b;
  localparam opcode_t OP_ISZERO = 6'h2c;
  localparam opcode_t OP_HALT   = 6'h2d;
  localparam opcode_t OP_TRAP   = 6'h2e;
  localparam opcode_t OP_RETI   = 6'h31;

  localparam opcode_t OP_LAST_LEGAL = 6'h39; // float opcodes still count as legal

  localparam int GREG_COUNT = 16;
  localparam int PREG_COUNT = 4;

  localparam word_t GREG_RESET_IMAGE [GREG_COUNT] = '{
    32'd0,  32'd1,  32'd2,  32'd3,  32'd4,  32'd5,  32'd6,  32'd7,
    32'd8,  32'd9,  32'd10, 32'd11, 32'd12, 32'd13, 32'd14, 32'd15
  };
  localparam logic PREG_RESET_IMAGE [PREG_COUNT] = '{1'b1, 1'b1, 1'b0, 1'b0};

  localparam int GUARD_BIT    = 31;
  localparam int GUARD_ID_MSB = 30;
  localparam int GUARD_ID_LSB = 29;
  localparam int OPCODE_MSB   = 28;
  localparam int OPCODE_LSB   = 23;
  localparam int RZ_MSB       = 22;
  localparam int RZ_LSB       = 19;
  localparam int RY_MSB       = 18;
  localparam int RY_LSB       = 15;
  localparam int RX_MSB       = 14;
  localparam int RX_LSB       = 11;

endpackage

`default_nettype wire

/* src/ctrl_table.sv */
`default_nettype none

module ctrl_table import decode_pkg::*; (
  input  opcode_t  opcode,
  output logic     reg_id_sel,
  output logic     pf_sel,
  output logic     src2_sel,
  output logic     link,
  output alu_op_t  alu_op,
  output logic     mem_read,
  output logic     mem_write,
  output logic     reg_mem,
  output logic     rw_p,
  output logic     rw_r,
  output logic     is_jump,
  output logic     jump_reg,
  output logic     has_rx,
  output logic     has_ry,
  output imm_sel_t imm_sel,
  output mask_t    set_mask,
  output logic     trap,
  output logic     bad_opcode
);

  // alu op shared by register, immediate and predicate forms
  always_comb
  begin
    case (opcode)
      OP_ADD_R, OP_ADDI, OP_LD, OP_ST, OP_ANDP: alu_op = 4'd1;
      OP_SUB_R, OP_SUBI, OP_ORP:                alu_op = 4'd2;
      OP_MUL_R, OP_MULI, OP_XORP:               alu_op = 4'd3;
      OP_DIV_R, OP_DIVI, OP_NOTP:               alu_op = 4'd4;
      OP_MOD_R, OP_MODI, OP_RTOP:               alu_op = 4'd5;
      OP_SHL_R, OP_SHLI, OP_ISNEG:              alu_op = 4'd6;
      OP_SHR_R, OP_SHRI, OP_ISZERO:             alu_op = 4'd7;
      OP_AND_R, OP_ANDI:                        alu_op = 4'd8;
      OP_OR_R, OP_ORI:                          alu_op = 4'd9;
      OP_XOR_R, OP_XORI:                        alu_op = 4'd10;
      OP_NEG:                                   alu_op = 4'd11;
      OP_NOT:                                   alu_op = 4'd12;
      OP_LDI:                                   alu_op = 4'd13;
      OP_JALI, OP_JALR:                         alu_op = 4'd14; // link value
      default:                                  alu_op = 4'd0;
    endcase
  end

  always_comb
  begin
    reg_id_sel = 1'b0;
    pf_sel     = 1'b0;
    src2_sel   = 1'b0;
    link       = 1'b0;
    mem_read   = 1'b0;
    mem_write  = 1'b0;
    reg_mem    = 1'b0;
    rw_p       = 1'b0;
    rw_r       = 1'b0;
    is_jump    = 1'b0;
    jump_reg   = 1'b0;
    has_rx     = 1'b0;
    has_ry     = 1'b0;
    imm_sel    = IMM_NONE;
    case (opcode)
      OP_ADD_R, OP_SUB_R, OP_MUL_R, OP_DIV_R, OP_MOD_R,
      OP_SHL_R, OP_SHR_R, OP_AND_R, OP_OR_R, OP_XOR_R:
      begin
        rw_r   = 1'b1;
        pf_sel = 1'b1;
        has_rx = 1'b1;
        has_ry = 1'b1;
      end
      OP_NEG, OP_NOT:
      begin
        rw_r   = 1'b1;
        pf_sel = 1'b1;
        has_ry = 1'b1;
      end
      OP_ADDI, OP_SUBI, OP_MULI, OP_DIVI, OP_MODI,
      OP_SHLI, OP_SHRI, OP_ANDI, OP_ORI, OP_XORI:
      begin
        rw_r     = 1'b1;
        pf_sel   = 1'b1;
        src2_sel = 1'b1;
        has_ry   = 1'b1;
        imm_sel  = IMM_15;
      end
      OP_LDI:
      begin
        rw_r     = 1'b1;
        pf_sel   = 1'b1;
        src2_sel = 1'b1;
        imm_sel  = IMM_19;
      end
      OP_LD:
      begin
        mem_read = 1'b1;
        reg_mem  = 1'b1;
        rw_r     = 1'b1;
        pf_sel   = 1'b1;
        src2_sel = 1'b1; // base + offset
        has_ry   = 1'b1;
        imm_sel  = IMM_15;
      end
      OP_ST:
      begin
        mem_write  = 1'b1;
        pf_sel     = 1'b1;
        src2_sel   = 1'b1;
        has_rx     = 1'b1;
        has_ry     = 1'b1;
        reg_id_sel = 1'b1; // store data comes from rz field
        imm_sel    = IMM_15;
      end
      OP_ANDP, OP_ORP, OP_XORP, OP_NOTP:
      begin
        rw_p = 1'b1;
      end
      OP_RTOP, OP_ISNEG, OP_ISZERO:
      begin
        rw_p   = 1'b1;
        has_ry = 1'b1;
      end
      OP_JMPI, OP_RETI:
      begin
        is_jump  = 1'b1;
        jump_reg = 1'b1;
        imm_sel  = IMM_23;
      end
      OP_JMPR:
      begin
        jump_reg   = 1'b1;
        has_rx     = 1'b1;
        reg_id_sel = 1'b1;
      end
      OP_JALI:
      begin
        link     = 1'b1;
        rw_r     = 1'b1;
        pf_sel   = 1'b1;
        is_jump  = 1'b1;
        jump_reg = 1'b1;
        imm_sel  = IMM_19;
      end
      OP_JALR:
      begin
        link     = 1'b1;
        rw_r     = 1'b1;
        pf_sel   = 1'b1;
        jump_reg = 1'b1;
        has_rx   = 1'b1;
      end
      default:
      begin
        rw_r = 1'b0; // nop, privileged and float ops
      end
    endcase
  end

  always_comb
  begin
    case (opcode)
      OP_DI:   set_mask = MASK_DI;
      OP_EI:   set_mask = MASK_EI;
      OP_HALT: set_mask = MASK_HALT;
      default: set_mask = MASK_NONE;
    endcase
  end

  assign trap       = (opcode == OP_TRAP);
  assign bad_opcode = (opcode > OP_LAST_LEGAL);

  // a memory op is either a load or a store
  always_comb
  begin
    assert (!(mem_read && mem_write))
      else $error("opcode %h decodes as both load and store", opcode);
  end

endmodule

`default_nettype wire

/* src/reg_bank.sv */
`default_nettype none

module reg_bank #(
  parameter type entry_t     = logic,
  parameter int  DEPTH       = 4,
  parameter int  READ_PORTS  = 2,
  parameter entry_t RESET_IMAGE [DEPTH] = '{default: '0}
) (
  input  logic                     clk,
  input  logic                     rst,
  input  logic                     we,
  input  logic [$clog2(DEPTH)-1:0] wr_id,
  input  entry_t                   wr_data,
  input  logic [$clog2(DEPTH)-1:0] rd_id [READ_PORTS],
  output entry_t                   rd_data [READ_PORTS]
);

  entry_t mem [DEPTH];

  // reset image wins over a write in the same cycle
  always_ff @(posedge clk)
  begin
    if (rst)
    begin
      mem <= RESET_IMAGE;
    end
    else if (we)
    begin
      mem[wr_id] <= wr_data;
    end
  end

  // async read, new value visible after the write edge
  always_comb
  begin
    for (int p = 0; p < READ_PORTS; p++)
    begin
      rd_data[p] = mem[rd_id[p]];
    end
  end

  wr_id_known: assert property (
    @(posedge clk) disable iff (rst)
    we |-> !$isunknown(wr_id)
  ) else $error("register write with unknown id");

endmodule

`default_nettype wire

/* src/operand_unit.sv */
`default_nettype none

module operand_unit import decode_pkg::*; (
  input  word_t    inst,
  input  word_t    pc_next,
  input  word_t    epc,
  input  imm_sel_t imm_sel,
  input  logic     reg_id_sel,
  output greg_id_t x_id,
  output greg_id_t y_id,
  output greg_id_t dest_id,
  output word_t    imm,
  output word_t    jump_target
);

  opcode_t opcode;

  assign opcode = inst[OPCODE_MSB:OPCODE_LSB];

  // st and jmpr read their operand from the rz slot
  assign x_id    = reg_id_sel ? inst[RZ_MSB:RZ_LSB] : inst[RX_MSB:RX_LSB];
  assign y_id    = inst[RY_MSB:RY_LSB];
  assign dest_id = inst[RZ_MSB:RZ_LSB];

  always_comb
  begin
    case (imm_sel)
      IMM_15:  imm = {{17{inst[14]}}, inst[14:0]};
      IMM_23:  imm = {{9{inst[22]}}, inst[22:0]};
      IMM_19:  imm = {{13{inst[18]}}, inst[18:0]};
      default: imm = '0;
    endcase
  end

  // reti returns to the saved pc, everything else is pc relative
  always_comb
  begin
    if (opcode == OP_RETI)
    begin
      jump_target = epc;
    end
    else
    begin
      jump_target = pc_next + imm;
    end
  end

endmodule

`default_nettype wire

/* src/decode_stage.sv */
`default_nettype none

module decode_stage import decode_pkg::*; (
  input  logic     clk,
  input  logic     rst,
  input  word_t    inst,
  input  word_t    pc_next,
  input  word_t    epc,
  input  logic     preg_we,
  input  preg_id_t preg_wr_id,
  input  logic     preg_wr_data,
  input  logic     greg_we,
  input  greg_id_t greg_wr_id,
  input  word_t    greg_wr_data,
  output logic     pf_sel,
  output logic     src2_sel,
  output logic     link,
  output alu_op_t  alu_op,
  output logic     mem_read,
  output logic     mem_write,
  output logic     reg_mem,
  output logic     rw_p,
  output logic     rw_r,
  output logic     is_jump,
  output logic     jump_reg,
  output logic     has_rx,
  output logic     has_ry,
  output mask_t    set_mask,
  output logic     trap,
  output logic     bad_opcode,
  output logic     px,
  output logic     py,
  output logic     pred_ok,
  output word_t    rx,
  output word_t    ry,
  output greg_id_t x_id,
  output greg_id_t y_id,
  output greg_id_t dest_id,
  output word_t    imm,
  output word_t    jump_target
);

  imm_sel_t imm_sel;
  logic     reg_id_sel;
  logic     pred_val;
  preg_id_t pred_rd_id [3];
  logic     pred_rd_data [3];
  greg_id_t greg_rd_id [2];
  word_t    greg_rd_data [2];

  ctrl_table u_ctrl (
    .opcode     (inst[OPCODE_MSB:OPCODE_LSB]),
    .reg_id_sel (reg_id_sel),
    .pf_sel     (pf_sel),
    .src2_sel   (src2_sel),
    .link       (link),
    .alu_op     (alu_op),
    .mem_read   (mem_read),
    .mem_write  (mem_write),
    .reg_mem    (reg_mem),
    .rw_p       (rw_p),
    .rw_r       (rw_r),
    .is_jump    (is_jump),
    .jump_reg   (jump_reg),
    .has_rx     (has_rx),
    .has_ry     (has_ry),
    .imm_sel    (imm_sel),
    .set_mask   (set_mask),
    .trap       (trap),
    .bad_opcode (bad_opcode)
  );

  operand_unit u_operand (
    .inst        (inst),
    .pc_next     (pc_next),
    .epc         (epc),
    .imm_sel     (imm_sel),
    .reg_id_sel  (reg_id_sel),
    .x_id        (x_id),
    .y_id        (y_id),
    .dest_id     (dest_id),
    .imm         (imm),
    .jump_target (jump_target)
  );

  // predicate bank sees the low id bits, port 2 is the guard
  assign pred_rd_id[0] = x_id[1:0];
  assign pred_rd_id[1] = y_id[1:0];
  assign pred_rd_id[2] = inst[GUARD_ID_MSB:GUARD_ID_LSB];

  reg_bank #(
    .entry_t     (logic),
    .DEPTH       (PREG_COUNT),
    .READ_PORTS  (3),
    .RESET_IMAGE (PREG_RESET_IMAGE)
  ) pred_bank (
    .clk     (clk),
    .rst     (rst),
    .we      (preg_we),
    .wr_id   (preg_wr_id),
    .wr_data (preg_wr_data),
    .rd_id   (pred_rd_id),
    .rd_data (pred_rd_data)
  );

  assign greg_rd_id[0] = x_id;
  assign greg_rd_id[1] = y_id;

  reg_bank #(
    .entry_t     (word_t),
    .DEPTH       (GREG_COUNT),
    .READ_PORTS  (2),
    .RESET_IMAGE (GREG_RESET_IMAGE)
  ) greg_bank (
    .clk     (clk),
    .rst     (rst),
    .we      (greg_we),
    .wr_id   (greg_wr_id),
    .wr_data (greg_wr_data),
    .rd_id   (greg_rd_id),
    .rd_data (greg_rd_data)
  );

  assign px       = pred_rd_data[0];
  assign py       = pred_rd_data[1];
  assign pred_val = pred_rd_data[2];
  assign rx       = greg_rd_data[0];
  assign ry       = greg_rd_data[1];

  assign pred_ok = inst[GUARD_BIT] ? pred_val : 1'b1; // unguarded always executes

endmodule

`default_nettype wire

/* test/decode_tb_clock.sv */
`default_nettype none

module decode_tb_clock #(
  parameter int HALF_PERIOD  = 50,
  parameter int RESET_CYCLES = 8
) (
  output logic clk,
  output logic rst
);

  initial
  begin
    clk = 1'b0;
    forever #HALF_PERIOD clk = ~clk;
  end

  initial
  begin
    rst = 1'b1;
    repeat (RESET_CYCLES) @(posedge clk);
    #10 rst = 1'b0; // same offset as the stimulus
  end

endmodule

`default_nettype wire

/* test/decode_tb.sv */
`default_nettype none

module decode_tb import decode_pkg::*; ();

  localparam int N_ROWS       = 53;
  localparam int CYCLE_LIMIT  = 8 + 2 * N_ROWS + 20;
  localparam int DRIVE_DELAY  = 10;
  localparam int SAMPLE_DELAY = 80; // 90 after the edge

  // ctl bits, msb first
  // x_from_rz pf src2 link | mrd mwr rmem | rw_p rw_r | jump jreg | hrx hry | trap bad
  typedef struct packed {
    opcode_t     op;
    logic [2:0]  grd;  // guard bit and guard id
    logic        wr;   // write both banks, next row keeps the fields
    imm_sel_t    isel;
    logic [14:0] ctl;
    alu_op_t     alu;
    mask_t       mask;
  } row_t;

  localparam row_t VEC [N_ROWS] = '{
    '{6'h00,      3'b000, 1'b0, IMM_NONE, 15'b0_000_000_00_00_00_00, 4'd0,  MASK_NONE},
    '{6'h00,      3'b100, 1'b0, IMM_NONE, 15'b0_000_000_00_00_00_00, 4'd0,  MASK_NONE},
    '{6'h00,      3'b101, 1'b0, IMM_NONE, 15'b0_000_000_00_00_00_00, 4'd0,  MASK_NONE},
    '{6'h00,      3'b110, 1'b0, IMM_NONE, 15'b0_000_000_00_00_00_00, 4'd0,  MASK_NONE},
    '{6'h00,      3'b111, 1'b0, IMM_NONE, 15'b0_000_000_00_00_00_00, 4'd0,  MASK_NONE},
    '{6'h00,      3'b010, 1'b0, IMM_NONE, 15'b0_000_000_00_00_00_00, 4'd0,  MASK_NONE},
    '{6'h00,      3'b000, 1'b0, IMM_NONE, 15'b0_000_000_00_00_00_00, 4'd0,  MASK_NONE},
    '{6'h00,      3'b000, 1'b0, IMM_NONE, 15'b0_000_000_00_00_00_00, 4'd0,  MASK_NONE},
    '{OP_DI,      3'b000, 1'b0, IMM_NONE, 15'b0_000_000_00_00_00_00, 4'd0,  MASK_DI},
    '{OP_EI,      3'b000, 1'b0, IMM_NONE, 15'b0_000_000_00_00_00_00, 4'd0,  MASK_EI},
    '{OP_NEG,     3'b101, 1'b0, IMM_NONE, 15'b0_100_000_01_00_01_00, 4'd11, MASK_NONE},
    '{OP_NOT,     3'b000, 1'b0, IMM_NONE, 15'b0_100_000_01_00_01_00, 4'd12, MASK_NONE},
    '{OP_AND_R,   3'b000, 1'b0, IMM_NONE, 15'b0_100_000_01_00_11_00, 4'd8,  MASK_NONE},
    '{OP_OR_R,    3'b000, 1'b0, IMM_NONE, 15'b0_100_000_01_00_11_00, 4'd9,  MASK_NONE},
    '{OP_XOR_R,   3'b000, 1'b0, IMM_NONE, 15'b0_100_000_01_00_11_00, 4'd10, MASK_NONE},
    '{OP_ADD_R,   3'b000, 1'b1, IMM_NONE, 15'b0_100_000_01_00_11_00, 4'd1,  MASK_NONE},
    '{OP_SUB_R,   3'b100, 1'b0, IMM_NONE, 15'b0_100_000_01_00_11_00, 4'd2,  MASK_NONE},
    '{OP_MUL_R,   3'b000, 1'b0, IMM_NONE, 15'b0_100_000_01_00_11_00, 4'd3,  MASK_NONE},
    '{OP_DIV_R,   3'b000, 1'b0, IMM_NONE, 15'b0_100_000_01_00_11_00, 4'd4,  MASK_NONE},
    '{OP_MOD_R,   3'b000, 1'b0, IMM_NONE, 15'b0_100_000_01_00_11_00, 4'd5,  MASK_NONE},
    '{OP_SHL_R,   3'b000, 1'b0, IMM_NONE, 15'b0_100_000_01_00_11_00, 4'd6,  MASK_NONE},
    '{OP_SHR_R,   3'b000, 1'b0, IMM_NONE, 15'b0_100_000_01_00_11_00, 4'd7,  MASK_NONE},
    '{OP_ANDI,    3'b000, 1'b0, IMM_15,   15'b0_110_000_01_00_01_00, 4'd8,  MASK_NONE},
    '{OP_ORI,     3'b000, 1'b0, IMM_15,   15'b0_110_000_01_00_01_00, 4'd9,  MASK_NONE},
    '{OP_XORI,    3'b000, 1'b0, IMM_15,   15'b0_110_000_01_00_01_00, 4'd10, MASK_NONE},
    '{OP_ADDI,    3'b000, 1'b1, IMM_15,   15'b0_110_000_01_00_01_00, 4'd1,  MASK_NONE},
    '{OP_SUBI,    3'b111, 1'b0, IMM_15,   15'b0_110_000_01_00_01_00, 4'd2,  MASK_NONE},
    '{OP_MULI,    3'b000, 1'b0, IMM_15,   15'b0_110_000_01_00_01_00, 4'd3,  MASK_NONE},
    '{OP_DIVI,    3'b000, 1'b0, IMM_15,   15'b0_110_000_01_00_01_00, 4'd4,  MASK_NONE},
    '{OP_MODI,    3'b000, 1'b0, IMM_15,   15'b0_110_000_01_00_01_00, 4'd5,  MASK_NONE},
    '{OP_SHLI,    3'b000, 1'b0, IMM_15,   15'b0_110_000_01_00_01_00, 4'd6,  MASK_NONE},
    '{OP_SHRI,    3'b000, 1'b0, IMM_15,   15'b0_110_000_01_00_01_00, 4'd7,  MASK_NONE},
    '{OP_JALI,    3'b000, 1'b0, IMM_19,   15'b0_101_000_01_11_00_00, 4'd14, MASK_NONE},
    '{OP_JALR,    3'b000, 1'b0, IMM_NONE, 15'b0_101_000_01_01_10_00, 4'd14, MASK_NONE},
    '{OP_JMPI,    3'b000, 1'b0, IMM_23,   15'b0_000_000_00_11_00_00, 4'd0,  MASK_NONE},
    '{OP_JMPR,    3'b000, 1'b0, IMM_NONE, 15'b1_000_000_00_01_10_00, 4'd0,  MASK_NONE},
    '{OP_LD,      3'b000, 1'b0, IMM_15,   15'b0_110_101_01_00_01_00, 4'd1,  MASK_NONE},
    '{OP_ST,      3'b000, 1'b0, IMM_15,   15'b1_110_010_00_00_11_00, 4'd1,  MASK_NONE},
    '{OP_LDI,     3'b000, 1'b0, IMM_19,   15'b0_110_000_01_00_00_00, 4'd13, MASK_NONE},
    '{OP_RTOP,    3'b000, 1'b1, IMM_NONE, 15'b0_000_000_10_00_01_00, 4'd5,  MASK_NONE},
    '{OP_ANDP,    3'b111, 1'b0, IMM_NONE, 15'b0_000_000_10_00_00_00, 4'd1,  MASK_NONE},
    '{OP_ORP,     3'b000, 1'b0, IMM_NONE, 15'b0_000_000_10_00_00_00, 4'd2,  MASK_NONE},
    '{OP_XORP,    3'b000, 1'b0, IMM_NONE, 15'b0_000_000_10_00_00_00, 4'd3,  MASK_NONE},
    '{OP_NOTP,    3'b000, 1'b0, IMM_NONE, 15'b0_000_000_10_00_00_00, 4'd4,  MASK_NONE},
    '{OP_ISNEG,   3'b000, 1'b0, IMM_NONE, 15'b0_000_000_10_00_01_00, 4'd6,  MASK_NONE},
    '{OP_ISZERO,  3'b000, 1'b0, IMM_NONE, 15'b0_000_000_10_00_01_00, 4'd7,  MASK_NONE},
    '{OP_HALT,    3'b000, 1'b0, IMM_NONE, 15'b0_000_000_00_00_00_00, 4'd0,  MASK_HALT},
    '{OP_TRAP,    3'b000, 1'b0, IMM_NONE, 15'b0_000_000_00_00_00_10, 4'd0,  MASK_NONE},
    '{OP_RETI,    3'b110, 1'b0, IMM_23,   15'b0_000_000_00_11_00_00, 4'd0,  MASK_NONE},
    '{6'h32,      3'b000, 1'b0, IMM_NONE, 15'b0_000_000_00_00_00_00, 4'd0,  MASK_NONE},
    '{6'h39,      3'b000, 1'b0, IMM_NONE, 15'b0_000_000_00_00_00_00, 4'd0,  MASK_NONE},
    '{6'h3a,      3'b000, 1'b0, IMM_NONE, 15'b0_000_000_00_00_00_01, 4'd0,  MASK_NONE},
    '{6'h3f,      3'b000, 1'b0, IMM_NONE, 15'b0_000_000_00_00_00_01, 4'd0,  MASK_NONE}
  };

  logic     clk;
  logic     rst;
  word_t    inst;
  word_t    pc_next;
  word_t    epc;
  logic     preg_we;
  preg_id_t preg_wr_id;
  logic     preg_wr_data;
  logic     greg_we;
  greg_id_t greg_wr_id;
  word_t    greg_wr_data;
  logic     pf_sel;
  logic     src2_sel;
  logic     link;
  alu_op_t  alu_op;
  logic     mem_read;
  logic     mem_write;
  logic     reg_mem;
  logic     rw_p;
  logic     rw_r;
  logic     is_jump;
  logic     jump_reg;
  logic     has_rx;
  logic     has_ry;
  mask_t    set_mask;
  logic     trap;
  logic     bad_opcode;
  logic     px;
  logic     py;
  logic     pred_ok;
  word_t    rx;
  word_t    ry;
  greg_id_t x_id;
  greg_id_t y_id;
  greg_id_t dest_id;
  word_t    imm;
  word_t    jump_target;

  word_t greg_model [GREG_COUNT];
  logic  preg_model [PREG_COUNT];
  word_t rng = 32'd37;
  int    row_idx = -1;
  int    cycles = 0;

  decode_tb_clock clock_gen (
    .clk (clk),
    .rst (rst)
  );

  decode_stage uut (.*);

  function automatic word_t xorshift32(input word_t s);
    word_t x;
    x = s;
    x = x ^ (x << 13);
    x = x ^ (x >> 17);
    x = x ^ (x << 5);
    return x;
  endfunction

  // sign extension picked by the immediate kind
  function automatic word_t expect_imm(input imm_sel_t kind, input logic [22:0] f);
    case (kind)
      IMM_15:  return {{17{f[14]}}, f[14:0]};
      IMM_19:  return {{13{f[18]}}, f[18:0]};
      IMM_23:  return {{9{f[22]}}, f[22:0]};
      default: return '0;
    endcase
  endfunction

  task automatic stop_run(input string line);
    $display("%s", line);
    $display("Verification failed");
    $fatal(1, "simulation stopped");
  endtask

  task automatic mismatch(input string what, input string got, input string exp);
    stop_run($sformatf("** Error at time %0t: row %0d %s is %s, expected %s",
                       $time, row_idx, what, got, exp));
  endtask

  task automatic check_word(input string what, input word_t got, input word_t exp);
    if (got !== exp)
    begin
      mismatch(what, $sformatf("%h", got), $sformatf("%h", exp));
    end
  endtask

  task automatic check_bit(input string what, input logic got, input logic exp);
    if (got !== exp)
    begin
      mismatch(what, $sformatf("%b", got), $sformatf("%b", exp));
    end
  endtask

  task automatic check_id(input string what, input greg_id_t got, input greg_id_t exp);
    if (got !== exp)
    begin
      mismatch(what, $sformatf("%0d", got), $sformatf("%0d", exp));
    end
  endtask

  task automatic check_alu_op(input string what, input alu_op_t got, input alu_op_t exp);
    if (got !== exp)
    begin
      mismatch(what, $sformatf("%0d", got), $sformatf("%0d", exp));
    end
  endtask

  task automatic check_mask(input string what, input mask_t got, input mask_t exp);
    if (got !== exp)
    begin
      mismatch(what, $sformatf("%b", got), $sformatf("%b", exp));
    end
  endtask

  always @(posedge clk)
  begin
    cycles <= cycles + 1;
    if (cycles >= CYCLE_LIMIT)
    begin
      stop_run($sformatf("the run did not finish within %0d clock cycles", CYCLE_LIMIT));
    end
  end

  initial
  begin
    row_t        r;
    logic [22:0] low;
    logic        hold;
    word_t       wdata;
    greg_id_t    ex_x;
    greg_id_t    ex_y;
    word_t       ex_imm;
    inst         = '0;
    pc_next      = '0;
    epc          = '0;
    preg_we      = 1'b1; // these writes land while rst is high
    preg_wr_id   = 2'd2;
    preg_wr_data = 1'b1;
    greg_we      = 1'b1;
    greg_wr_id   = 4'd5;
    greg_wr_data = 32'hdead_beef;
    for (int i = 0; i < GREG_COUNT; i++)
    begin
      greg_model[i] = word_t'(i);
    end
    preg_model = '{1'b1, 1'b1, 1'b0, 1'b0};
    hold = 1'b0;
    low  = '0;
    @(negedge rst);
    for (int n = 0; n < N_ROWS; n++)
    begin
      row_idx = n;
      r = VEC[n];
      if (n < 8)
      begin
        low = {4'd0, 4'(2 * n + 1), 4'(2 * n), 11'd0}; // walk every register id
      end
      else if (!hold)
      begin
        rng = xorshift32(rng);
        low = rng[22:0];
      end
      hold = r.wr;
      rng = xorshift32(rng);
      pc_next = rng;
      rng = xorshift32(rng);
      epc = rng;
      rng = xorshift32(rng);
      wdata = rng;
      ex_x = r.ctl[14] ? low[22:19] : low[14:11];
      ex_y = low[18:15];
      ex_imm = expect_imm(r.isel, low);
      inst         = {r.grd, r.op, low};
      greg_we      = r.wr;
      greg_wr_id   = ex_x;
      greg_wr_data = wdata;
      preg_we      = r.wr;
      preg_wr_id   = ex_y[1:0];
      preg_wr_data = ~preg_model[ex_y[1:0]]; // flips the stored bit
      #SAMPLE_DELAY;
      check_alu_op("alu_op", alu_op, r.alu);
      check_mask("set_mask", set_mask, r.mask);
      check_bit("pf_sel", pf_sel, r.ctl[13]);
      check_bit("src2_sel", src2_sel, r.ctl[12]);
      check_bit("link", link, r.ctl[11]);
      check_bit("mem_read", mem_read, r.ctl[10]);
      check_bit("mem_write", mem_write, r.ctl[9]);
      check_bit("reg_mem", reg_mem, r.ctl[8]);
      check_bit("rw_p", rw_p, r.ctl[7]);
      check_bit("rw_r", rw_r, r.ctl[6]);
      check_bit("is_jump", is_jump, r.ctl[5]);
      check_bit("jump_reg", jump_reg, r.ctl[4]);
      check_bit("has_rx", has_rx, r.ctl[3]);
      check_bit("has_ry", has_ry, r.ctl[2]);
      check_bit("trap", trap, r.ctl[1]);
      check_bit("bad_opcode", bad_opcode, r.ctl[0]);
      check_id("x_id", x_id, ex_x);
      check_id("y_id", y_id, ex_y);
      check_id("dest_id", dest_id, low[22:19]);
      check_word("imm", imm, ex_imm);
      check_word("jump_target", jump_target, (r.op == OP_RETI) ? epc : pc_next + ex_imm);
      check_word("rx", rx, greg_model[ex_x]); // old value until the edge
      check_word("ry", ry, greg_model[ex_y]);
      check_bit("px", px, preg_model[ex_x[1:0]]);
      check_bit("py", py, preg_model[ex_y[1:0]]);
      check_bit("pred_ok", pred_ok, r.grd[2] ? preg_model[r.grd[1:0]] : 1'b1);
      if (r.wr)
      begin
        greg_model[ex_x] = wdata;
        preg_model[ex_y[1:0]] = ~preg_model[ex_y[1:0]];
      end
      @(posedge clk);
      #DRIVE_DELAY;
    end
    $display("Verification passed");
    $finish;
  end

endmodule

`default_nettype wire

/* decode_stage.f */
src/decode_pkg.sv
src/ctrl_table.sv
src/reg_bank.sv
src/operand_unit.sv
src/decode_stage.sv
test/decode_tb_clock.sv
test/decode_tb.sv

/* Makefile */
# Verilator build and run of the decode stage testbench

VERILATOR ?= verilator
TOP       ?= decode_tb
FILELIST  ?= decode_stage.f
OBJ_DIR   ?= obj_dir
VFLAGS    ?= --binary --timing --assert -j 0

.PHONY: sim clean

# a $fatal in the testbench gives a non-zero exit status
sim:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(OBJ_DIR) -f $(FILELIST)
	./$(OBJ_DIR)/V$(TOP)

clean:
	rm -rf $(OBJ_DIR)
